// ==== Makefile ====
.PHONY: all run clean

all: run

obj_dir/Vmrma_tb: list.f $(wildcard src/*.sv) $(wildcard test/*.sv)
	verilator --binary --timing --assert -Wno-fatal --top-module mrma_tb -Mdir obj_dir -f list.f

run: obj_dir/Vmrma_tb
	./obj_dir/Vmrma_tb > sim.log 2>&1; cat sim.log
	grep -q "^TEST RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== list.f ====
src/mrma_pkg.sv
src/rr_arbiter.sv
src/prio_rotator.sv
src/mrma_ctrl.sv
src/match_matrix.sv
src/mrma_top.sv
test/mrma_props.sv
test/mrma_tb.sv

// ==== src/match_matrix.sv ====
// configuration matrix storing client and resource matches and their acknowledges
module match_matrix
   import mrma_pkg::*;
(
   input  logic             clk,
   input  logic             rst_n,
   input  matrix_op_e       op,     // command from the controller
   input  pick_t            pick,   // pair to store on op_set
   input  logic [n_cli-1:0] c,      // client requests
   output cfg_mat_t         cfg,    // stored matches
   output logic [n_cli-1:0] ca,     // client acknowledges
   output logic [n_res-1:0] ra      // resource acknowledges
);

   cfg_mat_t cfg_nxt;

   // next matrix
   always_comb begin
      cfg_nxt = cfg;

      // release every column whose client dropped its request
      for (int j = 0; j < n_cli; j++) begin
         if (!c[j]) begin
            for (int i = 0; i < n_res; i++)
               cfg_nxt[i][j] = 1'b0;
         end
      end

      // controller command
      case (op)
         op_flush: cfg_nxt = '0;                        // drop all matches
         op_set:   cfg_nxt[pick.res][pick.cli] = 1'b1;  // new pair
         default:  ;
      endcase
   end

   // matrix register
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n)
         cfg <= '0;
      else
         cfg <= cfg_nxt;
   end

   // acknowledge reduction
   // ca is the OR down a column
   // ra is the OR along a row
   always_comb begin
      ca = '0;
      for (int j = 0; j < n_cli; j++) begin
         for (int i = 0; i < n_res; i++)
            ca[j] = ca[j] | cfg[i][j];
      end
   end

   always_comb begin
      for (int i = 0; i < n_res; i++)
         ra[i] = |cfg[i];      // resource busy while any client holds it
   end

   // resource offer is never looked at here
   // so a withdrawn offer leaves the match standing

endmodule

// ==== src/mrma_ctrl.sv ====
// match controller choosing set or flush or nothing on every cycle
module mrma_ctrl
   import mrma_pkg::*;
(
   input  logic        clk,
   input  logic        rst_n,
   input  logic        flush,   // single cycle clear strobe
   input  pick_t       pick,    // pair offered by the arbiters
   output matrix_op_e  op,      // command to the matrix
   output ctrl_state_e state    // current controller state
);

   ctrl_state_e state_nxt;

   // command decode
   // flush beats a set in the same cycle
   always_comb begin
      if (flush)
         op = op_flush;
      else if (state == st_flush)
         op = op_none;          // clients still withdrawing
      else if (pick.valid)
         op = op_set;
      else
         op = op_none;
   end

   // next state
   always_comb begin
      case (state)
         st_flush: begin
            // one blocked cycle then back to normal
            if (flush)
               state_nxt = st_flush;
            else
               state_nxt = st_idle;
         end
         default: begin
            if (flush)
               state_nxt = st_flush;
            else if (pick.valid)
               state_nxt = st_match;
            else
               state_nxt = st_idle;
         end
      endcase
   end

   // state register
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n)
         state <= st_idle;
      else
         state <= state_nxt;     // updates every edge
   end

endmodule

// ==== src/mrma_pkg.sv ====
// shared sizes and types for the clocked multi-resource match arbiter
package mrma_pkg;

   // subsystem size
   localparam int n_cli = 4;        // clients
   localparam int n_res = 3;        // resources
   localparam int cli_w = 2;        // client index width
   localparam int res_w = 2;        // resource index width

   // controller states
   typedef enum logic [1:0] {
      st_idle,                      // nothing matched last edge
      st_match,                     // a pair was set last edge
      st_flush                      // matching blocked for one cycle
   } ctrl_state_e;

   // controller to matrix command
   typedef enum logic [1:0] {
      op_none,
      op_set,                       // store the current pick
      op_flush                      // clear every match
   } matrix_op_e;

   // winning pair of the current cycle
   typedef struct packed {
      logic             valid;      // both arbiters granted
      logic [cli_w-1:0] cli;        // client index
      logic [res_w-1:0] res;        // resource index
   } pick_t;

   // configuration matrix
   // one row per resource and one column per client
   typedef logic [n_res-1:0][n_cli-1:0] cfg_mat_t;

endpackage

// ==== src/mrma_top.sv ====
// clocked multi-resource match arbiter top level pairing clients with free resources
module mrma_top
   import mrma_pkg::*;
(
   input  logic             clk,
   input  logic             rst_n,
   input  logic [n_cli-1:0] c,      // client requests
   input  logic [n_res-1:0] r,      // resource offers
   input  logic             flush,  // clear all matches
   output logic [n_cli-1:0] ca,     // client acknowledges
   output logic [n_res-1:0] ra,     // resource acknowledges
   output cfg_mat_t         cfg     // configuration matrix
);

   logic [n_cli-1:0] free_cli, gnt_cli;
   logic [n_res-1:0] free_res, gnt_res;
   logic [cli_w-1:0] cli_ptr;
   logic [res_w-1:0] res_ptr;
   pick_t            pick;
   matrix_op_e       op;

   // only unmatched parties compete
   assign free_cli = c & ~ca;
   assign free_res = r & ~ra;

   rr_arbiter #(.width(n_cli)) u_cli_arb (.req(free_cli), .ptr(cli_ptr), .gnt(gnt_cli));
   rr_arbiter #(.width(n_res)) u_res_arb (.req(free_res), .ptr(res_ptr), .gnt(gnt_res));

   // one-hot grants to winner indices
   always_comb begin
      pick.valid = (|gnt_cli) & (|gnt_res);   // pair needs both sides
      pick.cli   = '0;
      pick.res   = '0;
      for (int j = 0; j < n_cli; j++)
         if (gnt_cli[j]) pick.cli = cli_w'(j);
      for (int i = 0; i < n_res; i++)
         if (gnt_res[i]) pick.res = res_w'(i);
   end

   prio_rotator u_rot  (.clk, .rst_n, .op, .pick, .cli_ptr, .res_ptr);
   mrma_ctrl    u_ctrl (.clk, .rst_n, .flush, .pick, .op, .state());  // state kept local
   match_matrix u_mat  (.clk, .rst_n, .op, .pick, .c, .cfg, .ca, .ra);

endmodule

// ==== src/prio_rotator.sv ====
// priority rotator moving the client and resource pointers past the last winners
module prio_rotator
   import mrma_pkg::*;
(
   input  logic             clk,
   input  logic             rst_n,
   input  matrix_op_e       op,       // command issued this cycle
   input  pick_t            pick,     // pair being set
   output logic [cli_w-1:0] cli_ptr,  // client arbiter start point
   output logic [res_w-1:0] res_ptr   // resource arbiter start point
);

   logic [cli_w-1:0] cli_nxt;         // winner plus one with wrap
   logic [res_w-1:0] res_nxt;

   // last winner goes to the back of the queue
   always_comb begin
      if (pick.cli == cli_w'(n_cli - 1))
         cli_nxt = '0;                // wrap at n_cli
      else
         cli_nxt = pick.cli + 1'b1;

      if (pick.res == res_w'(n_res - 1))
         res_nxt = '0;                // wrap at n_res
      else
         res_nxt = pick.res + 1'b1;
   end

   // pointers only move when a pair is stored
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         cli_ptr <= '0;
         res_ptr <= '0;
      end else if (op == op_set) begin
         cli_ptr <= cli_nxt;
         res_ptr <= res_nxt;
      end
   end

endmodule

// ==== src/rr_arbiter.sv ====
// round-robin arbiter granting one request at or after a rotating pointer
module rr_arbiter #(
   parameter int width = 4                   // number of request lines
) (
   input  logic [width-1:0]         req,     // request vector
   input  logic [$clog2(width)-1:0] ptr,     // highest priority position
   output logic [width-1:0]         gnt      // one-hot grant
);

   // scan starts at ptr and wraps past the top
   // first set request in that order wins
   // no request gives an all zero grant
   always_comb begin
      int unsigned idx;                      // position being checked
      logic        found;                    // a winner is already taken

      gnt   = '0;
      found = 1'b0;

      for (int unsigned i = 0; i < width; i++) begin
         // wrap the scan position
         idx = (int'(ptr) + i) % width;

         if (req[idx] && !found) begin
            gnt[idx] = 1'b1;                 // first hit wins
            found    = 1'b1;                 // later hits ignored
         end
      end
   end

   // a few notes on use
   // ptr is kept below width by the rotator
   // the modulo still keeps a stray value in range
   // the grant is purely combinational and has no state

endmodule

// ==== test/mrma_props.sv ====
// match matrix checker for row and column exclusivity, acknowledge reduction and flush
module mrma_props
   import mrma_pkg::*;
(
   input logic             clk,
   input logic             rst_n,
   input matrix_op_e       op,     // command seen by the matrix
   input cfg_mat_t         cfg,    // stored matches
   input logic [n_cli-1:0] ca,
   input logic [n_res-1:0] ra
);
   timeunit 1ns;
   timeprecision 100ps;

   logic [n_cli-1:0][n_res-1:0] cols;   // matrix seen column first

   always_comb begin
      for (int j = 0; j < n_cli; j++)
         for (int i = 0; i < n_res; i++)
            cols[j][i] = cfg[i][j];
   end

   // one client per resource, ra follows its row
   for (genvar i = 0; i < n_res; i++) begin : g_row
      a_row_excl: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(cfg[i]))
         else $error("resource %0d holds more than one client", i);
      a_ra_or: assert property (@(posedge clk) disable iff (!rst_n) ra[i] == (|cfg[i]))
         else $error("ra[%0d] differs from its row OR", i);
   end

   // one resource per client, ca follows its column
   for (genvar j = 0; j < n_cli; j++) begin : g_col
      a_col_excl: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(cols[j]))
         else $error("client %0d holds more than one resource", j);
      a_ca_or: assert property (@(posedge clk) disable iff (!rst_n) ca[j] == (|cols[j]))
         else $error("ca[%0d] differs from its column OR", j);
   end

   a_flush_clear: assert property (@(posedge clk) disable iff (!rst_n) op == op_flush |=> cfg == '0)
      else $error("matrix not empty in the cycle after a flush");

endmodule

// ==== test/mrma_stimulus.txt ====
# columns: test c r flush hold ca ra, masks in hex, hold in clock cycles
# ca and ra are the acknowledges expected once the hold is over
1 0 0 0 1 0 0
2 4 2 0 1 4 2
2 0 0 0 1 0 0
3 f 7 0 1 8 4
3 f 7 0 1 9 5
3 f 7 0 1 b 7
3 f 7 0 2 b 7
4 e 7 0 1 a 6
4 e 7 0 1 e 7
5 e 7 1 1 0 0
5 e 7 0 1 0 0
5 e 7 0 1 8 2
5 e 7 0 2 e 7
6 e 5 0 2 e 7
6 6 5 0 1 6 5
6 0 0 0 1 0 0

// ==== test/mrma_tb.sv ====
// testbench for the match arbiter with file stimulus and a cycle reference model
module mrma_tb
   import mrma_pkg::*;
();
   timeunit 1ns;
   timeprecision 100ps;

   logic             clk, rst_n, flush;
   logic [n_cli-1:0] c, ca;
   logic [n_res-1:0] r, ra;
   cfg_mat_t         cfg;

   cfg_mat_t m_cfg;                      // model matrix
   int       m_cli_ptr, m_res_ptr;      // model priority pointers
   bit       m_block;                   // model blocks one cycle after flush
   int       errors, test_errors, tests_passed, tests_failed;

   mrma_top uut (.clk, .rst_n, .c, .r, .flush, .ca, .ra, .cfg);

   bind match_matrix mrma_props u_props (.clk, .rst_n, .op, .cfg, .ca, .ra);

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;           // 40 ns period
   end

   // guard against a stuck run
   initial begin
      #100us;
      $display("timeout: simulation did not finish within 100 us");
      $display("TEST RESULT: FAIL");
      $finish;
   end

   function automatic logic [n_cli-1:0] model_ca(cfg_mat_t m);
      logic [n_cli-1:0] v;
      v = '0;
      for (int j = 0; j < n_cli; j++)
         for (int i = 0; i < n_res; i++)
            if (m[i][j]) v[j] = 1'b1;   // client holds some resource
      return v;
   endfunction

   function automatic logic [n_res-1:0] model_ra(cfg_mat_t m);
      logic [n_res-1:0] v;
      v = '0;
      for (int i = 0; i < n_res; i++)
         for (int j = 0; j < n_cli; j++)
            if (m[i][j]) v[i] = 1'b1;
      return v;
   endfunction

   task automatic note_error();
      errors++;
      test_errors++;
   endtask

   // one model edge with release first and then flush or block or one new pair
   task automatic step_model();
      cfg_mat_t         nxt;
      logic [n_cli-1:0] free_c;
      logic [n_res-1:0] free_r;
      int               wc, wr, idx;
      nxt    = m_cfg;
      free_c = c & ~model_ca(m_cfg);    // requesting and not yet matched
      free_r = r & ~model_ra(m_cfg);
      wc     = -1;
      wr     = -1;
      for (int j = 0; j < n_cli; j++)
         if (!c[j])
            for (int i = 0; i < n_res; i++) nxt[i][j] = 1'b0;
      for (int k = 0; k < n_cli; k++) begin
         idx = (m_cli_ptr + k) % n_cli;  // scan from the pointer, wrapping
         if (wc < 0 && free_c[idx]) wc = idx;
      end
      for (int k = 0; k < n_res; k++) begin
         idx = (m_res_ptr + k) % n_res;
         if (wr < 0 && free_r[idx]) wr = idx;
      end
      if (flush) begin
         nxt     = '0;
         m_block = 1'b1;
      end else if (m_block) begin
         m_block = 1'b0;                // clients still withdrawing
      end else if (wc >= 0 && wr >= 0) begin
         nxt[wr][wc] = 1'b1;
         m_cli_ptr   = (wc + 1) % n_cli; // last winner goes last
         m_res_ptr   = (wr + 1) % n_res;
      end
      m_cfg = nxt;
   endtask

   // one clock, then compare the matrix once it has settled
   task automatic run_cycle();
      @(posedge clk);
      step_model();
      #2;
      if (cfg !== m_cfg) begin
         $display("error at %0t: cfg is %h, model predicts %h", $time, cfg, m_cfg);
         note_error();
      end
   endtask

   task automatic report_test(int num);
      if (test_errors == 0) begin
         $display("test %0d passed", num);
         tests_passed++;
      end else begin
         $display("test %0d failed with %0d errors", num, test_errors);
         tests_failed++;
      end
      test_errors = 0;
   endtask

   initial begin
      int    fd, n, tnum, cur_test, hold, vc, vr, vf, eca, era, wait_cnt;
      string line;
      c = '0;
      r = '0;
      flush = 1'b0;
      rst_n = 1'b0;
      m_cfg = '0;
      m_cli_ptr = 0;
      m_res_ptr = 0;
      m_block = 1'b0;
      errors = 0;
      test_errors = 0;
      tests_passed = 0;
      tests_failed = 0;
      for (int k = 0; k < 10; k++) begin
         @(posedge clk);
         #2;
         if (cfg !== '0 || ca !== '0 || ra !== '0) begin
            $display("error at %0t: outputs not zero during reset", $time);
            note_error();
         end
      end
      rst_n = 1'b1;                     // released 2 ns after an edge
      fd = $fopen("test/mrma_stimulus.txt", "r");
      if (fd == 0) begin
         $display("could not open the stimulus file test/mrma_stimulus.txt");
         $display("TEST RESULT: FAIL");
         $finish;
      end else begin
         cur_test = 1;
         while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line.getc(0) == "#") continue;  // blank or header
            n = $sscanf(line, "%d %h %h %h %d %h %h", tnum, vc, vr, vf, hold, eca, era);
            if (n != 7) begin
               $display("malformed stimulus line: %s", line);
               note_error();
               continue;
            end
            if (tnum != cur_test) begin
               report_test(cur_test);
               cur_test = tnum;
            end
            c     = vc[n_cli-1:0];
            r     = vr[n_res-1:0];
            flush = vf[0];
            for (int k = 0; k < hold; k++) begin
               run_cycle();
               flush = 1'b0;            // strobe lasts one cycle
            end
            if (ca !== eca[n_cli-1:0] || ra !== era[n_res-1:0]) begin
               $display("error at %0t: test %0d ca %h ra %h, expected ca %h ra %h",
                        $time, tnum, ca, ra, eca[n_cli-1:0], era[n_res-1:0]);
               note_error();
            end
            if (model_ca(m_cfg) != eca[n_cli-1:0] || model_ra(m_cfg) != era[n_res-1:0]) begin
               $display("error at %0t: test %0d model and stimulus file disagree", $time, tnum);
               note_error();
            end
         end
         report_test(cur_test);
         $fclose(fd);
         // all requests gone, acknowledges must drain
         c = '0;
         r = '0;
         wait_cnt = 0;
         while ((ca !== '0 || ra !== '0) && wait_cnt < 8) begin
            run_cycle();
            wait_cnt++;
         end
         if (ca !== '0 || ra !== '0) begin
            $display("timeout: acknowledges still high 8 cycles after all requests dropped");
            errors++;
         end
         $display("tests passed %0d, failed %0d, errors %0d", tests_passed, tests_failed, errors);
         if (errors == 0 && tests_failed == 0) begin
            $display("TEST RESULT: PASS");
         end else begin
            $display("TEST RESULT: FAIL");
         end
         $finish;
      end
   end

endmodule
